// ==== Bender.yml ====
package:
  name: debug_port

sources:
  - rtl/debugPkg.sv
  - rtl/asyncFifo.sv
  - rtl/cmdReceiver.sv
  - rtl/msgTransmitter.sv
  - rtl/cmdHandler.sv
  - rtl/debugTop.sv
  - target: simulation
    files:
      - testbench/debugTop_sva.sv
      - testbench/debugTb.sv

// ==== list.f ====
rtl/debugPkg.sv
rtl/asyncFifo.sv
rtl/cmdReceiver.sv
rtl/msgTransmitter.sv
rtl/cmdHandler.sv
rtl/debugTop.sv
testbench/debugTop_sva.sv
testbench/debugTb.sv

// ==== rtl/asyncFifo.sv ====
module asyncFifo #(
    parameter int Depth = debugPkg::FifoDepth
) (
    // write side
    input  logic       wClk,
    input  logic       wRstN,
    input  logic       write,
    input  logic [7:0] wData,
    output logic       writeOk,
    // read side
    input  logic       rClk,
    input  logic       rRstN,
    input  logic       read,
    output logic [7:0] rData,
    output logic       readOk
);
    // one extra pointer bit tells full from empty
    localparam int AddrW = $clog2(Depth);

    // storage
    logic [7:0] mem [Depth];

    // write domain pointers
    logic [AddrW:0] wBin;
    logic [AddrW:0] wGray;
    logic [AddrW:0] wBinNext;
    // read pointer brought into the write domain
    logic [AddrW:0] rGraySync1;
    logic [AddrW:0] rGraySync2;

    // read domain pointers
    logic [AddrW:0] rBin;
    logic [AddrW:0] rGray;
    logic [AddrW:0] rBinNext;
    // write pointer brought into the read domain
    logic [AddrW:0] wGraySync1;
    logic [AddrW:0] wGraySync2;

    // ============================================================
    // write side
    // ============================================================

    // full when the top two gray bits differ and the rest match
    assign writeOk  = (wGray != {~rGraySync2[AddrW -: 2], rGraySync2[AddrW-2:0]});
    assign wBinNext = wBin + {{AddrW{1'b0}}, (write && writeOk)};

    always_ff @(posedge wClk) begin
        if (write && writeOk) begin
            mem[wBin[AddrW-1:0]] <= wData;
        end
    end

    always_ff @(posedge wClk or negedge wRstN) begin
        if (!wRstN) begin
            wBin       <= '0;
            wGray      <= '0;
            rGraySync1 <= '0;
            rGraySync2 <= '0;
        end else begin
            wBin       <= wBinNext;
            wGray      <= wBinNext ^ (wBinNext >> 1);
            // two-flop synchronizer
            rGraySync1 <= rGray;
            rGraySync2 <= rGraySync1;
        end
    end

    // ============================================================
    // read side
    // ============================================================

    // head entry shown ahead of the read strobe
    assign rData    = mem[rBin[AddrW-1:0]];
    assign readOk   = (rGray != wGraySync2);
    assign rBinNext = rBin + {{AddrW{1'b0}}, (read && readOk)};

    always_ff @(posedge rClk or negedge rRstN) begin
        if (!rRstN) begin
            rBin       <= '0;
            rGray      <= '0;
            wGraySync1 <= '0;
            wGraySync2 <= '0;
        end else begin
            rBin       <= rBinNext;
            rGray      <= rBinNext ^ (rBinNext >> 1);
            wGraySync1 <= wGray;
            wGraySync2 <= wGraySync1;
        end
    end

endmodule

// ==== rtl/cmdHandler.sv ====
module cmdHandler (
    input  logic               clk,
    input  logic               rstN,
    input  debugPkg::cmdWord_t cmd,
    input  logic               cmdReady,
    output logic               cmdTake,
    output logic [7:0]         msgByte,
    output logic [7:0]         msgLen,
    input  logic               msgTake,
    output logic [3:0]         led
);
    logic ledOn;
    logic isLedOff;
    logic isLedOn;
    // no pop in flight and no reply pending
    logic idle;

    // ============================================================
    // decode
    // ============================================================

    // ctrl group, op selects off or on
    assign isLedOff = cmd.fields.ctrl && (cmd.fields.op == debugPkg::CmdLedOff[6:0]);
    assign isLedOn  = cmd.fields.ctrl && (cmd.fields.op == debugPkg::CmdLedOn[6:0]);

    assign idle = !cmdTake && (msgLen == 8'd0);

    // upper leds unused
    assign led = {3'b000, ledOn};

    // ============================================================
    // command pop
    // ============================================================

    // one-cycle pulse, cmd is sampled while it is high
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cmdTake <= 1'b0;
        end else begin
            cmdTake <= idle && cmdReady;
        end
    end

    // led state and reply count
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ledOn  <= 1'b0;
            msgLen <= 8'd0;
        end else if (cmdTake) begin
            // anything else is dropped without a reply
            if (isLedOff || isLedOn) begin
                ledOn  <= isLedOn;
                msgLen <= 8'(debugPkg::ReplyLen);
            end
        end else if (msgTake) begin
            msgLen <= msgLen - 8'd1;
        end
    end

    // ============================================================
    // reply bytes
    // ============================================================

    // header is the command itself
    // then a countdown from msgLen-1
    always_ff @(posedge clk) begin
        if (cmdTake) begin
            msgByte <= cmd.raw;
        end else if (msgTake) begin
            msgByte <= msgLen - 8'd1;
        end
    end

endmodule

// ==== rtl/cmdReceiver.sv ====
module cmdReceiver (
    input  logic               clk,
    input  logic               rstN,
    input  logic               debugClk,
    input  logic               debugCs,
    input  logic               debugDi,
    output debugPkg::cmdWord_t cmd,
    output logic               cmdReady,
    input  logic               cmdTake
);
    // bit 8 is the sentinel, never part of the byte
    logic [8:0] shiftReg;
    // sentinel at the top, byte complete
    logic       byteDone;
    logic       fifoWrite;
    logic       fifoRoom;
    logic [7:0] fifoData;

    // ============================================================
    // serial input on debugClk
    // ============================================================

    assign byteDone = shiftReg[8];

    // start as if one sentinel was already loaded
    always_ff @(posedge debugClk or negedge rstN) begin
        if (!rstN) begin
            shiftReg <= 9'h001;
        end else if (debugCs) begin
            if (byteDone) begin
                // new sentinel plus the first bit of the next byte
                shiftReg <= {7'd0, 1'b1, debugDi};
            end else begin
                // msb first
                shiftReg <= {shiftReg[7:0], debugDi};
            end
        end
    end

    // full FIFO drops the byte
    assign fifoWrite = debugCs && byteDone && fifoRoom;

    // ============================================================
    // crossing into clk
    // ============================================================

    asyncFifo #(
        .Depth(debugPkg::FifoDepth)
    ) cmdFifo (
        .wClk    (debugClk),
        .wRstN   (rstN),
        .write   (fifoWrite),
        .wData   (shiftReg[7:0]),
        .writeOk (fifoRoom),
        .rClk    (clk),
        .rRstN   (rstN),
        .read    (cmdTake),
        .rData   (fifoData),
        .readOk  (cmdReady)
    );

    assign cmd.raw = fifoData;

endmodule

// ==== rtl/debugPkg.sv ====
package debugPkg;

    // ============================================================
    // command codes
    // ============================================================

    // no operation
    localparam logic [7:0] CmdNop    = 8'h00;
    // clear led[0]
    localparam logic [7:0] CmdLedOff = 8'h80;
    // set led[0]
    localparam logic [7:0] CmdLedOn  = 8'h81;

    // ============================================================
    // framing and buffering
    // ============================================================

    // bytes handed over per reply, header included
    // on the wire a frame is header, length ReplyLen-1 and payload ReplyLen-1 down to 1
    localparam int ReplyLen = 4;

    // entries per async FIFO as a power of two
    localparam int FifoDepth = 8;

    // field view of a command byte
    typedef struct packed {
        // set for control commands
        logic       ctrl;
        // operation within the control group
        logic [6:0] op;
    } cmdFields_t;

    // one command byte, raw or decoded
    typedef union packed {
        logic [7:0] raw;
        cmdFields_t fields;
    } cmdWord_t;

endpackage

// ==== rtl/debugTop.sv ====
module debugTop (
    input  logic       clk,
    input  logic       rstN,
    input  logic       debugClk,
    input  logic       debugCs,
    input  logic       debugDi,
    output logic       debugDo,
    output logic [3:0] led
);
    // receiver to handler
    debugPkg::cmdWord_t cmd;
    logic               cmdReady;
    logic               cmdTake;
    // handler to transmitter
    logic [7:0]         msgByte;
    logic [7:0]         msgLen;
    logic               msgTake;

    cmdReceiver cmdRx (
        .clk      (clk),
        .rstN     (rstN),
        .debugClk (debugClk),
        .debugCs  (debugCs),
        .debugDi  (debugDi),
        .cmd      (cmd),
        .cmdReady (cmdReady),
        .cmdTake  (cmdTake)
    );

    cmdHandler handler (
        .clk      (clk),
        .rstN     (rstN),
        .cmd      (cmd),
        .cmdReady (cmdReady),
        .cmdTake  (cmdTake),
        .msgByte  (msgByte),
        .msgLen   (msgLen),
        .msgTake  (msgTake),
        .led      (led)
    );

    msgTransmitter msgTx (
        .clk      (clk),
        .rstN     (rstN),
        .msgByte  (msgByte),
        .msgLen   (msgLen),
        .msgTake  (msgTake),
        .debugClk (debugClk),
        .debugCs  (debugCs),
        .debugDo  (debugDo)
    );

endmodule

// ==== rtl/msgTransmitter.sv ====
module msgTransmitter (
    input  logic       clk,
    input  logic       rstN,
    input  logic [7:0] msgByte,
    input  logic [7:0] msgLen,
    output logic       msgTake,
    input  logic       debugClk,
    input  logic       debugCs,
    output logic       debugDo
);
    // framing FSM states
    localparam logic [1:0] SIdle    = 2'd0;
    localparam logic [1:0] SHeader  = 2'd1;
    localparam logic [1:0] SLength  = 2'd2;
    localparam logic [1:0] SPayload = 2'd3;

    logic [1:0] state;
    logic       fifoWrite;
    logic       fifoRoom;
    logic [7:0] fifoData;

    // serial side
    // bit 0 is the sentinel, bit 8 drives debugDo
    logic [8:0] shiftReg;
    // second zero byte of an idle frame still due
    logic       zeroPending;
    // fetch strobe, raised one bit before the byte ends
    logic       readReq;
    logic       byteEnd;
    logic       outRead;
    logic       outOk;
    logic [7:0] outData;

    // ============================================================
    // frame builder on clk
    // ============================================================

    always_comb begin
        fifoWrite = 1'b0;
        fifoData  = msgByte;
        msgTake   = 1'b0;
        case (state)
            SHeader: begin
                fifoWrite = 1'b1;
            end
            SLength: begin
                // length byte, and the header counts as taken
                fifoWrite = 1'b1;
                fifoData  = msgLen - 8'd1;
                msgTake   = fifoRoom;
            end
            SPayload: begin
                fifoWrite = (msgLen != 8'd0);
                msgTake   = (msgLen != 8'd0) && fifoRoom;
            end
            default: begin
                fifoWrite = 1'b0;
            end
        endcase
    end

    // full FIFO holds the state
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= SIdle;
        end else begin
            case (state)
                SIdle: begin
                    if (msgLen != 8'd0) begin
                        state <= SHeader;
                    end
                end
                SHeader: begin
                    if (fifoRoom) begin
                        state <= SLength;
                    end
                end
                SLength: begin
                    if (fifoRoom) begin
                        state <= SPayload;
                    end
                end
                default: begin
                    // handler has counted down to zero
                    if (msgLen == 8'd0) begin
                        state <= SIdle;
                    end
                end
            endcase
        end
    end

    asyncFifo #(
        .Depth(debugPkg::FifoDepth)
    ) msgFifo (
        .wClk    (clk),
        .wRstN   (rstN),
        .write   (fifoWrite),
        .wData   (fifoData),
        .writeOk (fifoRoom),
        .rClk    (debugClk),
        .rRstN   (rstN),
        .read    (outRead),
        .rData   (outData),
        .readOk  (outOk)
    );

    // ============================================================
    // serializer on debugClk
    // ============================================================

    assign debugDo = shiftReg[8];
    // sentinel one below the top, last bit on the line
    assign byteEnd = (shiftReg[7:0] == 8'h80);
    // empty FIFO ignores the strobe
    assign outRead = debugCs && readReq;

    // reset state is the first zero byte of an idle frame
    always_ff @(posedge debugClk or negedge rstN) begin
        if (!rstN) begin
            shiftReg    <= 9'h001;
            zeroPending <= 1'b1;
            readReq     <= 1'b0;
        end else if (debugCs) begin
            readReq <= (shiftReg[6:0] == 7'h40) && !zeroPending;
            if (!byteEnd) begin
                shiftReg <= {shiftReg[7:0], 1'b0};
            end else if (zeroPending) begin
                shiftReg    <= 9'h001;
                zeroPending <= 1'b0;
            end else if (readReq && outOk) begin
                shiftReg <= {outData, 1'b1};
            end else begin
                // nothing queued, start a new idle frame
                shiftReg    <= 9'h001;
                zeroPending <= 1'b1;
            end
        end
    end

endmodule

// ==== testbench/debugTb.sv ====
module debugTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ClkPeriod   = 4;
    localparam int DebugPeriod = 10;
    // burst long enough to overflow the command FIFO
    localparam int BurstCmds   = 2 * debugPkg::FifoDepth + 4;
    // LED commands over all tests, burst included
    localparam int LedCmds     = 2 + 3 + BurstCmds;
    // header, length and payload on the wire
    localparam int FrameBytes  = debugPkg::ReplyLen + 1;
    localparam int TimeoutCycles =
        LedCmds * FrameBytes * 9 * DebugPeriod / ClkPeriod + 25000;

    logic        clk;
    logic        rstN;
    logic        debugClk;
    logic        debugCs;
    logic        debugDi;
    logic        debugDo;
    logic [3:0]  led;
    logic [31:0] lfsr = 32'h424c;

    debugTop u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .debugClk (debugClk),
        .debugCs  (debugCs),
        .debugDi  (debugDi),
        .debugDo  (debugDo),
        .led      (led)
    );

    // ============================================================
    // clocks
    // ============================================================

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        debugClk = 1'b0;
        forever #(DebugPeriod / 2) debugClk = ~debugClk;
    end

    // ============================================================
    // random source
    // ============================================================

    // fibonacci, taps 32 22 2 1
    function automatic logic nextBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] randBits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], nextBit()};
        end
        return v;
    endfunction

    // ============================================================
    // serial host
    // ============================================================

    // msb first, sometimes behind a pause in debugCs
    task automatic sendByte(input logic [7:0] b);
        int gap;
        gap = (randBits(2) == 8'd0) ? int'(randBits(3)) + 1 : 0;
        repeat (gap) begin
            @(negedge debugClk);
            debugCs = 1'b0;
        end
        for (int i = 7; i >= 0; i--) begin
            @(negedge debugClk);
            debugCs = 1'b1;
            debugDi = b[i];
        end
    endtask

    // ctrl bit clear, never an LED command
    task automatic sendFiller();
        sendByte(randBits(7));
    endtask

    // one filler pushes the last command in, then keep clocking replies out
    task automatic drainReplies();
        sendFiller();
        while (u_dut.chk.pendingCount != 0) begin
            sendFiller();
        end
    endtask

    task automatic reportTest(input string name);
        $display("test %s finished, %0d assertion failures so far", name,
            u_dut.chk.failCount);
    endtask

    // ============================================================
    // test sequence
    // ============================================================

    initial begin
        logic [7:0] b;
        rstN    = 1'b0;
        debugCs = 1'b0;
        debugDi = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;

        // idle frames only
        repeat (4) sendByte(debugPkg::CmdNop);
        drainReplies();
        reportTest("idle after reset");

        sendByte(debugPkg::CmdLedOn);
        drainReplies();
        sendByte(debugPkg::CmdLedOff);
        drainReplies();
        reportTest("led on and off");

        sendByte(debugPkg::CmdLedOn);
        sendByte(debugPkg::CmdLedOn);
        sendByte(debugPkg::CmdLedOff);
        drainReplies();
        reportTest("one frame per command");

        // unknown codes, LED codes swapped for nop
        repeat (12) begin
            b = randBits(8);
            if (b == debugPkg::CmdLedOn || b == debugPkg::CmdLedOff) begin
                b = debugPkg::CmdNop;
            end
            sendByte(b);
        end
        drainReplies();
        reportTest("nop and unknown bytes");

        // well past FifoDepth so later commands meet a full FIFO
        repeat (BurstCmds) begin
            sendByte(randBits(1) != 8'd0 ? debugPkg::CmdLedOn : debugPkg::CmdLedOff);
        end
        drainReplies();
        reportTest("burst with pauses");

        $display("5 tests run, %0d assertion failures", u_dut.chk.failCount);
        if (u_dut.chk.failCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // ============================================================
    // timeout
    // ============================================================

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TimeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: replies still pending after %0d clk cycles", TimeoutCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== testbench/debugTop_sva.sv ====
module debugTopSva (
    input logic       clk,
    input logic       rstN,
    input logic       debugClk,
    input logic       debugCs,
    input logic       debugDi,
    input logic       debugDo,
    input logic [3:0] led,
    // command FIFO has room, decides if a host byte is kept
    input logic       fifoRoom
);
    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench
    int         failCount = 0;
    int         pendingCount;

    // accepted LED commands still waiting for their frame
    logic [7:0] expQ[$];

    // host byte assembly
    logic [7:0] rxAcc;
    logic [3:0] rxCnt;
    // debugDo byte assembly
    logic [7:0] txAcc;
    logic [2:0] txCnt;
    // 0 between frames, else index of the next byte in the frame
    logic [2:0] pos;

    // last finished debugDo byte, held for the properties
    logic       outValid;
    logic [7:0] outByte;
    logic [2:0] outPos;
    logic       expValid;
    logic [7:0] expHdr;
    // led[0] once every reply is out
    logic       ledExp;

    // ============================================================
    // stream decoders
    // ============================================================

    // both lines read at the edge that moves them
    always @(posedge debugClk or negedge rstN) begin
        debugPkg::cmdWord_t w;
        logic [7:0]         b;
        logic [2:0]         p;
        if (!rstN) begin
            rxAcc    <= '0;
            rxCnt    <= '0;
            txAcc    <= '0;
            txCnt    <= '0;
            pos      <= '0;
            outValid <= 1'b0;
            outByte  <= '0;
            outPos   <= '0;
            expValid <= 1'b0;
            expHdr   <= '0;
            ledExp   <= 1'b0;
            pendingCount <= 0;
            expQ.delete();
        end else begin
            p = pos;
            outValid <= 1'b0;
            if (debugCs) begin
                // reply side, msb first
                b = {txAcc[6:0], debugDo};
                txAcc <= b;
                txCnt <= txCnt + 3'd1;
                if (txCnt == 3'd7) begin
                    outValid <= 1'b1;
                    outByte  <= b;
                    outPos   <= p;
                    expValid <= 1'b0;
                    expHdr   <= '0;
                    if (p == 3'd0) begin
                        // zero bytes are idle fill
                        if (b != 8'h00) begin
                            p = 3'd1;
                            if (expQ.size() != 0) begin
                                expValid <= 1'b1;
                                expHdr   <= expQ[0];
                                ledExp   <= expQ[0][0];
                                void'(expQ.pop_front());
                            end
                        end
                    end else if (p == 3'(debugPkg::ReplyLen)) begin
                        p = 3'd0;
                    end else begin
                        p = p + 3'd1;
                    end
                end
                // host side, the byte is written on the first bit of the next
                if (rxCnt == 4'd8) begin
                    w.raw = rxAcc;
                    if (fifoRoom && w.fields.ctrl && (w.fields.op[6:1] == 6'd0)) begin
                        expQ.push_back(rxAcc);
                    end
                    rxAcc <= {7'd0, debugDi};
                    rxCnt <= 4'd1;
                end else begin
                    rxAcc <= {rxAcc[6:0], debugDi};
                    rxCnt <= rxCnt + 4'd1;
                end
            end
            pos <= p;
            pendingCount <= expQ.size() + ((p != 3'd0) ? 1 : 0);
        end
    end

    // ============================================================
    // frame and LED rules
    // ============================================================

    aNoStrayFrame: assert property (@(posedge debugClk) disable iff (!rstN)
        (outValid && outPos == 3'd0 && outByte != 8'h00) |-> expValid)
        else begin
            failCount++;
            $error("a frame with header %h came out while no LED command was pending",
                $sampled(outByte));
        end

    aHeader: assert property (@(posedge debugClk) disable iff (!rstN)
        (outValid && outPos == 3'd0 && expValid) |-> (outByte == expHdr))
        else begin
            failCount++;
            $error("ERR %0t debugDo header got %h exp %h", $time,
                $sampled(outByte), $sampled(expHdr));
        end

    aLength: assert property (@(posedge debugClk) disable iff (!rstN)
        (outValid && outPos == 3'd1) |-> (outByte == 8'(debugPkg::ReplyLen - 1)))
        else begin
            failCount++;
            $error("ERR %0t debugDo length got %h exp %h", $time,
                $sampled(outByte), 8'(debugPkg::ReplyLen - 1));
        end

    // payload counts down to 1, zero is never allowed inside a frame
    aPayload: assert property (@(posedge debugClk) disable iff (!rstN)
        (outValid && outPos >= 3'd2) |-> (outByte == 8'(debugPkg::ReplyLen + 1 - outPos)))
        else begin
            failCount++;
            $error("ERR %0t debugDo payload got %h exp %h", $time, $sampled(outByte),
                8'(debugPkg::ReplyLen + 1 - $sampled(outPos)));
        end

    aLedState: assert property (@(posedge debugClk) disable iff (!rstN)
        (pendingCount == 0) |-> (led[0] == ledExp))
        else begin
            failCount++;
            $error("ERR %0t led[0] got %b exp %b", $time, $sampled(led[0]), $sampled(ledExp));
        end

    aLedUpper: assert property (@(posedge clk) disable iff (!rstN)
        led[3:1] == 3'b000)
        else begin
            failCount++;
            $error("ERR %0t led[3:1] got %b exp 000", $time, $sampled(led[3:1]));
        end

endmodule

bind debugTop debugTopSva chk (
    .clk      (clk),
    .rstN     (rstN),
    .debugClk (debugClk),
    .debugCs  (debugCs),
    .debugDi  (debugDi),
    .debugDo  (debugDo),
    .led      (led),
    .fifoRoom (cmdRx.fifoRoom)
);
